// ==== common/misc_pkg.sv ====
`default_nettype none

package misc_pkg;

	// one bus request, zero wstrb means read
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} bus_req_t;

	localparam logic [3:0] REGION_MISC = 4'h2;

	// register index from addr[6:2]
	typedef logic [4:0] reg_idx_t;

	localparam reg_idx_t REG_LED       = 5'd0;
	localparam reg_idx_t REG_BTN       = 5'd1;
	localparam reg_idx_t REG_SOC_VER   = 5'd2;
	localparam reg_idx_t REG_FLASH_SEL = 5'd13;
	localparam reg_idx_t REG_GENIO_IN  = 5'd17;
	localparam reg_idx_t REG_GENIO_OUT = 5'd18;
	localparam reg_idx_t REG_GENIO_OE  = 5'd19;
	localparam reg_idx_t REG_GENIO_W2S = 5'd20;
	localparam reg_idx_t REG_GENIO_W2C = 5'd21;
	localparam reg_idx_t REG_GPEXT_IN  = 5'd22;
	localparam reg_idx_t REG_GPEXT_OUT = 5'd23;
	localparam reg_idx_t REG_GPEXT_OE  = 5'd24;
	localparam reg_idx_t REG_GPEXT_W2S = 5'd25;
	localparam reg_idx_t REG_GPEXT_W2C = 5'd26;

	typedef enum logic [2:0] {
		GPIO_NONE,
		GPIO_WR_OUT,
		GPIO_WR_OE,
		GPIO_SET_OUT,
		GPIO_CLR_OUT
	} gpio_op_t;

	typedef logic [29:0] genio_t;

	typedef struct packed {
		logic [7:0] pmod;
		logic [5:0] sao2;
		logic [5:0] sao1;
	} gpext_t;

	localparam int LED_W = 16;
	localparam int BTN_W = 8;

	localparam logic [31:0] SOC_VERSION = 32'h0;
	localparam logic [23:0] RELOAD_KEY  = 24'hD0F1A5;

	// select clock is high while the delay counter is in [LO, HI]
	localparam logic [2:0] FSEL_DELAY_START = 3'd7;
	localparam logic [2:0] FSEL_PULSE_HI    = 3'd5;
	localparam logic [2:0] FSEL_PULSE_LO    = 3'd3;

	function automatic gpext_t gpext_from_word(input logic [31:0] w);
		gpext_t g;
		g.pmod = w[23:16];
		g.sao2 = w[13:8];
		g.sao1 = w[5:0];
		return g;
	endfunction

	// unused bus bits read as zero
	function automatic logic [31:0] gpext_to_word(input gpext_t g);
		logic [31:0] w;
		w        = '0;
		w[23:16] = g.pmod;
		w[13:8]  = g.sao2;
		w[5:0]   = g.sao1;
		return w;
	endfunction

endpackage

`default_nettype wire

// ==== logic/misc_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module misc_decode (
	input  misc_pkg::bus_req_t bus_req,
	output logic               wr_en,
	output logic               rd_sel,
	output misc_pkg::reg_idx_t idx,
	output logic               ready,
	output logic               bus_error_irq
);

	import misc_pkg::*;

	logic in_misc;

	// region is the top address nibble
	assign in_misc = (bus_req.addr[31:28] == REGION_MISC);

	assign idx = bus_req.addr[6:2];

	// only the low strobe bit qualifies a register write
	assign wr_en  = bus_req.valid && in_misc && bus_req.wstrb[0];
	assign rd_sel = bus_req.valid && in_misc;

	// misc and unmapped accesses both finish in the same cycle
	assign ready = bus_req.valid;

	// unmapped access, interrupt follows valid
	assign bus_error_irq = bus_req.valid && !in_misc;

endmodule

`default_nettype wire

// ==== logic/gpio_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_bank #(
	parameter type payload_t = logic [31:0]
) (
	input  logic               clk48m,
	input  logic               rst,
	input  misc_pkg::gpio_op_t op,
	input  payload_t           wdata,
	output payload_t           out,
	output payload_t           oe
);

	import misc_pkg::*;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			out <= '0;
			oe  <= '0;
		end else begin
			case (op)
				GPIO_WR_OUT: begin
					out <= wdata;
				end
				GPIO_WR_OE: begin
					oe <= wdata;
				end
				// write-to-set
				GPIO_SET_OUT: begin
					out <= payload_t'(out | wdata);
				end
				// write-to-clear
				GPIO_CLR_OUT: begin
					out <= payload_t'(out & ~wdata);
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/flash_select_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_select_seq (
	input  logic clk48m,
	input  logic rst,
	input  logic sel_wr,
	input  logic sel_bit,
	input  logic key_ok,
	output logic fsel_d,
	output logic fsel_c,
	output logic programn
);

	import misc_pkg::*;

	logic       fsel_strobe;
	logic       reload_queued;
	logic       fpga_reload;
	logic [2:0] fsel_delay;

	// select bit, start strobe and sticky reload request
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_d        <= 1'b0;
			fsel_strobe   <= 1'b0;
			reload_queued <= 1'b0;
		end else begin
			fsel_strobe <= sel_wr;
			if (sel_wr) begin
				fsel_d <= sel_bit;
			end
			if (sel_wr && key_ok) begin
				reload_queued <= 1'b1;
			end
		end
	end

	// the select flip-flop gets its clock well after fsel_d settles,
	// and the reload only fires once that pulse is over
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_delay  <= '0;
			fpga_reload <= 1'b0;
		end else if (fsel_strobe) begin
			fsel_delay <= FSEL_DELAY_START;
		end else if (fsel_delay != 3'd0) begin
			fsel_delay <= fsel_delay - 3'd1;
			if (fsel_delay == 3'd1 && reload_queued) begin
				fpga_reload <= 1'b1;
			end
		end
	end

	assign fsel_c   = (fsel_delay >= FSEL_PULSE_LO) && (fsel_delay <= FSEL_PULSE_HI);
	assign programn = ~fpga_reload;

endmodule

`default_nettype wire

// ==== logic/misc_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module misc_regs (
	input  logic                       clk48m,
	input  logic                       rst,
	input  logic                       wr_en,
	input  misc_pkg::reg_idx_t         idx,
	input  logic [31:0]                wdata,
	output logic [misc_pkg::LED_W-1:0] led,
	output misc_pkg::genio_t           genio_out,
	output misc_pkg::genio_t           genio_oe,
	output misc_pkg::gpext_t           gpext_out,
	output misc_pkg::gpext_t           gpext_oe,
	output logic                       fsel_d,
	output logic                       fsel_c,
	output logic                       programn
);

	import misc_pkg::*;

	gpio_op_t genio_op;
	gpio_op_t gpext_op;
	logic     sel_wr;
	logic     key_ok;

	// per-bank write style from the register index
	always_comb begin
		genio_op = GPIO_NONE;
		gpext_op = GPIO_NONE;
		if (wr_en) begin
			case (idx)
				REG_GENIO_OUT: genio_op = GPIO_WR_OUT;
				REG_GENIO_OE:  genio_op = GPIO_WR_OE;
				REG_GENIO_W2S: genio_op = GPIO_SET_OUT;
				REG_GENIO_W2C: genio_op = GPIO_CLR_OUT;
				REG_GPEXT_OUT: gpext_op = GPIO_WR_OUT;
				REG_GPEXT_OE:  gpext_op = GPIO_WR_OE;
				REG_GPEXT_W2S: gpext_op = GPIO_SET_OUT;
				REG_GPEXT_W2C: gpext_op = GPIO_CLR_OUT;
				default: begin
				end
			endcase
		end
	end

	assign sel_wr = wr_en && (idx == REG_FLASH_SEL);

	// unlock key sits in the upper three bytes
	assign key_ok = (wdata[31:8] == RELOAD_KEY);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led <= '0;
		end else if (wr_en && idx == REG_LED) begin
			led <= wdata[LED_W-1:0];
		end
	end

	gpio_bank #(
		.payload_t(genio_t)
	) genio_bank (
		.clk48m(clk48m),
		.rst   (rst),
		.op    (genio_op),
		.wdata (genio_t'(wdata[29:0])),
		.out   (genio_out),
		.oe    (genio_oe)
	);

	gpio_bank #(
		.payload_t(gpext_t)
	) gpext_bank (
		.clk48m(clk48m),
		.rst   (rst),
		.op    (gpext_op),
		.wdata (gpext_from_word(wdata)),
		.out   (gpext_out),
		.oe    (gpext_oe)
	);

	flash_select_seq flash_select_seq (
		.clk48m  (clk48m),
		.rst     (rst),
		.sel_wr  (sel_wr),
		.sel_bit (wdata[0]),
		.key_ok  (key_ok),
		.fsel_d  (fsel_d),
		.fsel_c  (fsel_c),
		.programn(programn)
	);

endmodule

`default_nettype wire

// ==== logic/misc_readback.sv ====
`timescale 1ns/1ps
`default_nettype none

module misc_readback (
	input  misc_pkg::reg_idx_t         idx,
	input  logic                       rd_sel,
	input  logic [misc_pkg::LED_W-1:0] led,
	input  logic [misc_pkg::BTN_W-1:0] btn,
	input  misc_pkg::genio_t           genio_in,
	input  misc_pkg::genio_t           genio_out,
	input  misc_pkg::genio_t           genio_oe,
	input  misc_pkg::gpext_t           gpext_in,
	input  misc_pkg::gpext_t           gpext_out,
	input  misc_pkg::gpext_t           gpext_oe,
	input  logic                       usb_vdet,
	input  logic                       fsel_d,
	output logic [31:0]                rdata
);

	import misc_pkg::*;

	always_comb begin
		if (!rd_sel) begin
			// anything outside the misc region
			rdata = 32'hDEADBEEF;
		end else begin
			case (idx)
				REG_LED:       rdata = {{(32-LED_W){1'b0}}, led};
				// buttons are active low on the board
				REG_BTN:       rdata = {{(32-BTN_W){1'b0}}, ~btn};
				REG_SOC_VER:   rdata = SOC_VERSION;
				REG_FLASH_SEL: rdata = {31'h0, fsel_d};
				REG_GENIO_IN:  rdata = {2'b00, genio_in};
				REG_GENIO_OUT: rdata = {2'b00, genio_out};
				REG_GENIO_OE:  rdata = {2'b00, genio_oe};
				// usb supply detect rides along in bit 31
				REG_GPEXT_IN:  rdata = gpext_to_word(gpext_in) | {usb_vdet, 31'h0};
				REG_GPEXT_OUT: rdata = gpext_to_word(gpext_out);
				REG_GPEXT_OE:  rdata = gpext_to_word(gpext_oe);
				default:       rdata = 32'h0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/misc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module misc_top (
	input  logic                       clk48m,
	input  logic                       rst,
	input  misc_pkg::bus_req_t         bus_req,
	input  logic [misc_pkg::BTN_W-1:0] btn,
	input  misc_pkg::genio_t           genio_in,
	input  misc_pkg::gpext_t           gpext_in,
	input  logic                       usb_vdet,
	output logic [31:0]                rdata,
	output logic                       ready,
	output logic                       bus_error_irq,
	output logic [misc_pkg::LED_W-1:0] led,
	output misc_pkg::genio_t           genio_out,
	output misc_pkg::genio_t           genio_oe,
	output misc_pkg::gpext_t           gpext_out,
	output misc_pkg::gpext_t           gpext_oe,
	output logic                       fsel_d,
	output logic                       fsel_c,
	output logic                       programn
);

	import misc_pkg::*;

	logic     wr_en;
	logic     rd_sel;
	reg_idx_t idx;

	misc_decode misc_decode (
		.bus_req      (bus_req),
		.wr_en        (wr_en),
		.rd_sel       (rd_sel),
		.idx          (idx),
		.ready        (ready),
		.bus_error_irq(bus_error_irq)
	);

	misc_regs misc_regs (
		.clk48m   (clk48m),
		.rst      (rst),
		.wr_en    (wr_en),
		.idx      (idx),
		.wdata    (bus_req.wdata),
		.led      (led),
		.genio_out(genio_out),
		.genio_oe (genio_oe),
		.gpext_out(gpext_out),
		.gpext_oe (gpext_oe),
		.fsel_d   (fsel_d),
		.fsel_c   (fsel_c),
		.programn (programn)
	);

	misc_readback misc_readback (
		.idx      (idx),
		.rd_sel   (rd_sel),
		.led      (led),
		.btn      (btn),
		.genio_in (genio_in),
		.genio_out(genio_out),
		.genio_oe (genio_oe),
		.gpext_in (gpext_in),
		.gpext_out(gpext_out),
		.gpext_oe (gpext_oe),
		.usb_vdet (usb_vdet),
		.fsel_d   (fsel_d),
		.rdata    (rdata)
	);

endmodule

`default_nettype wire

// ==== tb/misc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module misc_checker (
	input  logic                       clk48m,
	input  logic                       rst,
	input  misc_pkg::bus_req_t         bus_req,
	input  logic [misc_pkg::BTN_W-1:0] btn,
	input  misc_pkg::genio_t           genio_in,
	input  misc_pkg::gpext_t           gpext_in,
	input  logic                       usb_vdet,
	input  logic [31:0]                rdata,
	input  logic                       ready,
	input  logic                       bus_error_irq,
	input  logic [misc_pkg::LED_W-1:0] led,
	input  misc_pkg::genio_t           genio_out,
	input  misc_pkg::genio_t           genio_oe,
	input  misc_pkg::gpext_t           gpext_out,
	input  misc_pkg::gpext_t           gpext_oe,
	input  logic                       fsel_d,
	input  logic                       fsel_c,
	input  logic                       programn,
	output int                         err_count,
	output int                         check_count
);

	import misc_pkg::*;

	// bus bits that carry pmod, sao2 and sao1
	localparam logic [31:0] EXT_MASK = 32'h00FF_3F3F;

	logic [LED_W-1:0] m_led;
	genio_t           m_genio_out;
	genio_t           m_genio_oe;
	logic [31:0]      m_ext_out;
	logic [31:0]      m_ext_oe;
	logic             m_fsel_d;
	int               m_age;
	logic             m_key_seen;
	logic             m_reload;
	logic             wr;
	reg_idx_t         idx;
	logic [31:0]      w;

	function automatic logic [31:0] ext_word(input gpext_t g);
		return {8'h00, g.pmod, 2'b00, g.sao2, 2'b00, g.sao1};
	endfunction

	function automatic logic [31:0] expected_rdata();
		if (bus_req.addr[31:28] != REGION_MISC) begin
			return 32'hDEAD_BEEF;
		end
		case (bus_req.addr[6:2])
			REG_LED:       return {{(32-LED_W){1'b0}}, m_led};
			REG_BTN:       return {{(32-BTN_W){1'b0}}, ~btn};
			REG_SOC_VER:   return 32'h0;
			REG_FLASH_SEL: return {31'h0, m_fsel_d};
			REG_GENIO_IN:  return {2'b00, genio_in};
			REG_GENIO_OUT: return {2'b00, m_genio_out};
			REG_GENIO_OE:  return {2'b00, m_genio_oe};
			REG_GPEXT_IN:  return {usb_vdet, 31'h0} | ext_word(gpext_in);
			REG_GPEXT_OUT: return m_ext_out;
			REG_GPEXT_OE:  return m_ext_oe;
			default:       return 32'h0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("FAIL time %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	initial begin
		err_count   = 0;
		check_count = 0;
	end

	// model follows every accepted request at the rising edge
	always @(posedge clk48m) begin
		if (rst) begin
			m_led       = '0;
			m_genio_out = '0;
			m_genio_oe  = '0;
			m_ext_out   = '0;
			m_ext_oe    = '0;
			m_fsel_d    = 1'b0;
			m_age       = 15;
			m_key_seen  = 1'b0;
			m_reload    = 1'b0;
		end else begin
			wr  = bus_req.valid && (bus_req.addr[31:28] == REGION_MISC) && bus_req.wstrb[0];
			idx = bus_req.addr[6:2];
			w   = bus_req.wdata;
			if (m_age < 15) begin
				m_age++;
			end
			if (wr) begin
				case (idx)
					REG_LED:       m_led = w[LED_W-1:0];
					REG_GENIO_OUT: m_genio_out = w[29:0];
					REG_GENIO_OE:  m_genio_oe = w[29:0];
					REG_GENIO_W2S: m_genio_out = m_genio_out | w[29:0];
					REG_GENIO_W2C: m_genio_out = m_genio_out & ~w[29:0];
					REG_GPEXT_OUT: m_ext_out = w & EXT_MASK;
					REG_GPEXT_OE:  m_ext_oe = w & EXT_MASK;
					REG_GPEXT_W2S: m_ext_out = m_ext_out | (w & EXT_MASK);
					REG_GPEXT_W2C: m_ext_out = m_ext_out & ~w;
					REG_FLASH_SEL: begin
						m_fsel_d = w[0];
						m_age    = 0;
						if (w[31:8] == RELOAD_KEY) begin
							m_key_seen = 1'b1;
						end
					end
					default: begin
					end
				endcase
			end
			// reload fires eight edges after the last select write
			if (m_key_seen && m_age == 8) begin
				m_reload = 1'b1;
			end
		end
	end

	// compare in the middle of the cycle, where everything has settled
	always @(negedge clk48m) begin
		if (!rst) begin
			check_value("ready", {31'h0, ready}, {31'h0, bus_req.valid});
			check_value("bus_error_irq", {31'h0, bus_error_irq},
				{31'h0, bus_req.valid && (bus_req.addr[31:28] != REGION_MISC)});
			if (bus_req.valid) begin
				check_value("rdata", rdata, expected_rdata());
			end
			check_value("led", {{(32-LED_W){1'b0}}, led}, {{(32-LED_W){1'b0}}, m_led});
			check_value("genio_out", {2'b00, genio_out}, {2'b00, m_genio_out});
			check_value("genio_oe", {2'b00, genio_oe}, {2'b00, m_genio_oe});
			check_value("gpext_out", ext_word(gpext_out), m_ext_out);
			check_value("gpext_oe", ext_word(gpext_oe), m_ext_oe);
			check_value("fsel_d", {31'h0, fsel_d}, {31'h0, m_fsel_d});
			// select clock pulse sits 3 to 5 edges after the write
			check_value("fsel_c", {31'h0, fsel_c}, {31'h0, (m_age >= 3) && (m_age <= 5)});
			check_value("programn", {31'h0, programn}, {31'h0, !m_reload});
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_misc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_misc_top;

	import misc_pkg::*;

	localparam int CLK_NS     = 40;
	localparam int N_PLAIN    = 60;
	localparam int N_SETCLR   = 60;
	localparam int N_UNMAPPED = 40;
	// reset, the register sweep, random tests, readback and flash sequences
	localparam int OP_TOTAL    = 4 + 2 + 32 + N_PLAIN + N_SETCLR + N_UNMAPPED + 5 + 35;
	localparam int WATCHDOG_NS = OP_TOTAL * CLK_NS + 100 * CLK_NS;

	logic             clk48m;
	logic             rst;
	bus_req_t         bus_req;
	logic [BTN_W-1:0] btn;
	genio_t           genio_in;
	gpext_t           gpext_in;
	logic             usb_vdet;
	logic [31:0]      rdata;
	logic             ready;
	logic             bus_error_irq;
	logic [LED_W-1:0] led;
	genio_t           genio_out;
	genio_t           genio_oe;
	gpext_t           gpext_out;
	gpext_t           gpext_oe;
	logic             fsel_d;
	logic             fsel_c;
	logic             programn;
	int               err_count;
	int               check_count;
	int               hs_errors;
	int               tests_run;
	int               test_base;
	logic [31:0]      lcg_state;

	always #(CLK_NS / 2) clk48m = ~clk48m;

	misc_top misc_top_i (
		.clk48m(clk48m), .rst(rst), .bus_req(bus_req), .btn(btn),
		.genio_in(genio_in), .gpext_in(gpext_in), .usb_vdet(usb_vdet),
		.rdata(rdata), .ready(ready), .bus_error_irq(bus_error_irq), .led(led),
		.genio_out(genio_out), .genio_oe(genio_oe), .gpext_out(gpext_out),
		.gpext_oe(gpext_oe), .fsel_d(fsel_d), .fsel_c(fsel_c), .programn(programn)
	);

	misc_checker misc_checker (
		.clk48m(clk48m), .rst(rst), .bus_req(bus_req), .btn(btn),
		.genio_in(genio_in), .gpext_in(gpext_in), .usb_vdet(usb_vdet),
		.rdata(rdata), .ready(ready), .bus_error_irq(bus_error_irq), .led(led),
		.genio_out(genio_out), .genio_oe(genio_oe), .gpext_out(gpext_out),
		.gpext_oe(gpext_oe), .fsel_d(fsel_d), .fsel_c(fsel_c), .programn(programn),
		.err_count(err_count), .check_count(check_count)
	);

	// each word takes the high halves of two LCG steps
	function automatic logic [31:0] rand_word();
		logic [15:0] hi;
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		hi        = lcg_state[31:16];
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {hi, lcg_state[31:16]};
	endfunction

	// misc address with random filler in the bits the decode ignores
	function automatic logic [31:0] misc_addr(input reg_idx_t ri);
		logic [31:0] r;
		r = rand_word();
		return {REGION_MISC, r[27:7], ri, r[1:0]};
	endfunction

	function automatic reg_idx_t pick_plain(input int k);
		case (k)
			0:       return REG_LED;
			1:       return REG_GENIO_OUT;
			2:       return REG_GENIO_OE;
			3:       return REG_GPEXT_OUT;
			default: return REG_GPEXT_OE;
		endcase
	endfunction

	function automatic reg_idx_t pick_setclr(input int k);
		case (k)
			0:       return REG_GENIO_W2S;
			1:       return REG_GENIO_W2C;
			2:       return REG_GPEXT_W2S;
			3:       return REG_GPEXT_W2C;
			4:       return REG_BTN;
			5:       return REG_GENIO_IN;
			6:       return REG_GPEXT_IN;
			7:       return REG_GENIO_OUT;
			default: return REG_GPEXT_OUT;
		endcase
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk48m);
			#2;
		end
	endtask

	// one bus access with fresh pin inputs that holds valid until ready
	task automatic access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb);
		logic [31:0] pins;
		logic [31:0] gio;
		int          waited;
		pins          = rand_word();
		gio           = rand_word();
		waited        = 0;
		btn           = pins[BTN_W-1:0];
		gpext_in      = gpext_t'(pins[27:8]);
		usb_vdet      = pins[31];
		genio_in      = gio[29:0];
		bus_req.valid = 1'b1;
		bus_req.addr  = addr;
		bus_req.wdata = wdata;
		bus_req.wstrb = wstrb;
		@(posedge clk48m);
		while (!ready && waited < 4) begin
			waited++;
			@(posedge clk48m);
		end
		if (!ready) begin
			hs_errors++;
			$display("time %0t: ready never came for the access to %h", $time, addr);
		end
		#2;
		bus_req.valid = 1'b0;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = err_count + hs_errors - test_base;
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errs);
		test_base = err_count + hs_errors;
	endtask

	initial begin
		int          k;
		logic [31:0] r;
		logic [31:0] addr;
		reg_idx_t    ri;
		clk48m    = 1'b0;
		rst       = 1'b1;
		bus_req   = '0;
		btn       = '0;
		genio_in  = '0;
		gpext_in  = '0;
		usb_vdet  = 1'b0;
		lcg_state = 32'd17454;
		hs_errors = 0;
		tests_run = 0;
		test_base = 0;
		repeat (4) @(posedge clk48m);
		#2;
		rst = 1'b0;

		idle_cycles(2);
		for (k = 0; k < 32; k++) begin
			access(misc_addr(reg_idx_t'(k)), rand_word(), 4'h0);
		end
		end_test("reset values and register sweep");

		// random strobes where only strobe bit 0 turns the access into a write
		for (k = 0; k < N_PLAIN; k++) begin
			r  = rand_word();
			ri = pick_plain(int'(r[10:8]) % 5);
			access(misc_addr(ri), rand_word(), r[3:0]);
		end
		end_test("plain writes and readback");

		for (k = 0; k < N_SETCLR; k++) begin
			r  = rand_word();
			ri = pick_setclr(int'(r[11:8]) % 9);
			if (ri == REG_GENIO_W2S || ri == REG_GENIO_W2C ||
					ri == REG_GPEXT_W2S || ri == REG_GPEXT_W2C) begin
				access(misc_addr(ri), rand_word(), 4'hF);
			end else begin
				access(misc_addr(ri), rand_word(), 4'h0);
			end
		end
		end_test("set and clear writes, input reads");

		for (k = 0; k < N_UNMAPPED; k++) begin
			r    = rand_word();
			addr = rand_word();
			if (addr[31:28] == REGION_MISC) begin
				addr[31:28] = 4'hA;
			end
			access(addr, rand_word(), r[3:0]);
		end
		for (k = 0; k < 5; k++) begin
			access(misc_addr(pick_plain(k)), rand_word(), 4'h0);
		end
		end_test("unmapped accesses");

		// a select write without the key and then one with it
		access(misc_addr(REG_FLASH_SEL), 32'h1234_5601, 4'hF);
		idle_cycles(14);
		if (programn !== 1'b1) begin
			hs_errors++;
			$display("time %0t: programn went low without the unlock key", $time);
		end
		access(misc_addr(REG_FLASH_SEL), {RELOAD_KEY, 8'h00}, 4'hF);
		idle_cycles(14);
		access(misc_addr(REG_FLASH_SEL), 32'h0, 4'h0);
		idle_cycles(4);
		if (programn !== 1'b0) begin
			hs_errors++;
			$display("time %0t: programn did not stay low after the key write", $time);
		end
		end_test("flash select and reload");

		$display("tests %0d, checks %0d, errors %0d", tests_run, check_count,
			err_count + hs_errors);
		if (err_count + hs_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/misc_pkg.sv
logic/misc_decode.sv
logic/gpio_bank.sv
logic/flash_select_seq.sv
logic/misc_regs.sv
logic/misc_readback.sv
logic/misc_top.sv
tb/misc_checker.sv
tb/tb_misc_top.sv

// ==== Bender.yml ====
package:
  name: misc_top

sources:
  # shared package first, then the RTL bottom up
  - files:
      - common/misc_pkg.sv
      - logic/misc_decode.sv
      - logic/gpio_bank.sv
      - logic/flash_select_seq.sv
      - logic/misc_regs.sv
      - logic/misc_readback.sv
      - logic/misc_top.sv

  # testbench sources
  - target: test
    files:
      - tb/misc_checker.sv
      - tb/tb_misc_top.sv
